// File: src.f
source/rv_exe_pkg.sv
source/alu.sv
source/reg_file.sv
source/inst_decode.sv
source/exe_stage.sv
source/rv_exe_top.sv
dv/rv_exe_tb.sv

// File: dv/rv_exe_trace.txt
// kind pc word events rd_or_size data addr_or_target
// kind 1 instruction, 2 idle gap, 0 end; events bit0 write, bit1 store, bit2 branch
2 0 0 0 0 0 0
2 0 0 0 0 0 0
2 0 0 0 0 0 0
1 100 123450b7 1 01 12345000 0
1 104 00001117 1 02 00001104 0
1 108 ffb00193 1 03 fffffffb 0
1 10c 00718213 1 04 00000002 0
1 110 004182b3 1 05 fffffffd 0
1 114 40508333 1 06 12345003 0
1 118 00421393 1 07 00000020 0
1 11c 4061d433 1 08 ffffffff 0
1 120 0061d4b3 1 09 1fffffff 0
1 124 00709533 1 0a 12345000 0
1 128 0041a5b3 1 0b 00000001 0
1 12c 0041b633 1 0c 00000000 0
1 130 fff23693 1 0d 00000001 0
1 134 0ff0c713 1 0e 123450ff 0
1 138 f0076793 1 0f ffffffff 0
1 13c 0067f833 1 10 12345003 0
1 140 4011d893 1 11 fffffffd 0
1 144 00108013 1 00 12345001 0
1 148 00000933 1 12 00000000 0
2 0 0 0 0 0 0
1 14c 00e080a3 2 1 000000ff 12345001
1 150 fee11f23 2 2 000050ff 00001102
1 154 04622023 2 3 12345003 00000042
1 158 5a500993 1 13 000005a5 0
1 15c 01399023 2 2 000005a5 000005a5
1 160 00420863 4 0 0 00000170
1 164 00418863 0 0 0 0
1 168 00419863 4 0 0 00000178
1 16c 00421863 0 0 0 0
1 170 0041c863 4 0 0 00000180
1 174 00324863 0 0 0 0
2 0 0 0 0 0 0
1 178 00325863 4 0 0 00000188
1 17c 0041d863 0 0 0 0
1 180 00326863 4 0 0 00000190
1 184 0041e863 0 0 0 0
1 188 0041f863 4 0 0 00000198
1 18c 00327863 0 0 0 0
1 190 fe0008e3 4 0 0 00000180
1 194 0000007f 0 0 0 0
1 198 fff00a13 1 14 ffffffff 0
1 19c 00000000 0 0 0 0
1 1a0 01426863 4 0 0 000001b0
1 1a4 10000aef 5 15 000001a8 000002a4
1 1a8 ff9ff06f 5 00 000001ac 000001a0
1 1ac 015a8b33 1 16 00000350 0
0 0 0 0 0 0 0

// File: dv/rv_exe_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the three stage execute pipeline
// trace loader, stimulus driver, retire event checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rv_exe_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// seven hex words per trace record
	localparam int REC_W       = 7;
	localparam int MAX_REC     = 96;
	localparam int DRAIN_LIMIT = 20;
	localparam int PERIOD      = 4;
	// two cycles from the driving edge to the checking edge
	localparam int CHECK_LAG   = 2;

	typedef struct packed {
		int                            rec;
		logic [rv_exe_pkg::REG_AW-1:0] rd;
		logic [rv_exe_pkg::XLEN-1:0]   data;
	} wb_exp_t;

	typedef struct packed {
		int                          rec;
		logic [rv_exe_pkg::XLEN-1:0] addr;
		logic [rv_exe_pkg::XLEN-1:0] data;
		rv_exe_pkg::store_e          size;
	} st_exp_t;

	typedef struct packed {
		int                          rec;
		logic [rv_exe_pkg::XLEN-1:0] target;
	} br_exp_t;

	logic                          clk_i;
	logic                          rst_i;
	logic                          inst_valid_i;
	rv_exe_pkg::inst_u             inst_i;
	logic [rv_exe_pkg::XLEN-1:0]   pc_i;
	logic                          wb_valid_o;
	logic [rv_exe_pkg::REG_AW-1:0] wb_rd_o;
	logic [rv_exe_pkg::XLEN-1:0]   wb_data_o;
	logic                          st_valid_o;
	logic [rv_exe_pkg::XLEN-1:0]   st_addr_o;
	logic [rv_exe_pkg::XLEN-1:0]   st_data_o;
	rv_exe_pkg::store_e            st_size_o;
	logic                          br_taken_o;
	logic [rv_exe_pkg::XLEN-1:0]   br_target_o;

	logic [31:0]                   trace_mem [REC_W*MAX_REC];
	time                           drive_t [MAX_REC];
	wb_exp_t                       wb_q [$];
	st_exp_t                       st_q [$];
	br_exp_t                       br_q [$];
	logic                          checking;

	rv_exe_top rv_exe_top_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.wb_valid_o   (wb_valid_o),
		.wb_rd_o      (wb_rd_o),
		.wb_data_o    (wb_data_o),
		.st_valid_o   (st_valid_o),
		.st_addr_o    (st_addr_o),
		.st_data_o    (st_data_o),
		.st_size_o    (st_size_o),
		.br_taken_o   (br_taken_o),
		.br_target_o  (br_target_o)
	);

	// 4 ns period
	always #(PERIOD / 2) clk_i = ~clk_i;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t ns %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	// walk the records, queue every expected retire event in order
	task automatic load_trace(output int n_rec);
		int          base;
		logic        done;
		logic [31:0] kind;
		logic [31:0] ev;
		wb_exp_t     wb_e;
		st_exp_t     st_e;
		br_exp_t     br_e;
		$readmemh("dv/rv_exe_trace.txt", trace_mem);
		n_rec = 0;
		done  = 1'b0;
		while (!done) begin
			if (n_rec >= MAX_REC) begin
				abort_run("the trace has no end record within its size limit");
			end
			base = n_rec * REC_W;
			kind = trace_mem[base];
			ev   = trace_mem[base+3];
			if (kind === 32'd0) begin
				done = 1'b1;
			end else if (kind === 32'd1 || kind === 32'd2) begin
				// bit0 write, bit1 store, bit2 branch
				if (kind === 32'd1 && ev[0]) begin
					wb_e.rec  = n_rec;
					wb_e.rd   = trace_mem[base+4][rv_exe_pkg::REG_AW-1:0];
					wb_e.data = trace_mem[base+5];
					wb_q.push_back(wb_e);
				end
				if (kind === 32'd1 && ev[1]) begin
					st_e.rec  = n_rec;
					st_e.size = rv_exe_pkg::store_e'(trace_mem[base+4][1:0]);
					st_e.data = trace_mem[base+5];
					st_e.addr = trace_mem[base+6];
					st_q.push_back(st_e);
				end
				if (kind === 32'd1 && ev[2]) begin
					br_e.rec    = n_rec;
					br_e.target = trace_mem[base+6];
					br_q.push_back(br_e);
				end
				n_rec++;
			end else begin
				abort_run("the trace file is missing or holds an unreadable record");
			end
		end
		if (n_rec == 0) begin
			abort_run("the trace file holds no instructions");
		end
	endtask

	// one record per falling edge, gaps park the bus
	task automatic drive_record(input int rec);
		int base;
		base = rec * REC_W;
		drive_t[rec] = $time;
		if (trace_mem[base] === 32'd1) begin
			inst_valid_i = 1'b1;
			pc_i         = trace_mem[base+1];
			inst_i       = trace_mem[base+2];
		end else begin
			inst_valid_i = 1'b0;
			pc_i         = '0;
			inst_i       = '0;
		end
	endtask

	// each raised strobe must match the head of its queue
	task automatic check_retire();
		wb_exp_t     wb_e;
		st_exp_t     st_e;
		br_exp_t     br_e;
		logic [31:0] lag;
		if (wb_valid_o !== 1'b0) begin
			if (wb_q.size() == 0) begin
				abort_run($sformatf("unexpected register write at %0t ns", $time));
			end
			wb_e = wb_q.pop_front();
			lag  = 32'(($time - drive_t[wb_e.rec]) / PERIOD);
			check_value("wb_valid_o", 32'(wb_valid_o), 32'd1);
			check_value("wb_valid_o lag", lag, 32'(CHECK_LAG));
			check_value("wb_rd_o", 32'(wb_rd_o), 32'(wb_e.rd));
			check_value("wb_data_o", wb_data_o, wb_e.data);
		end
		if (st_valid_o !== 1'b0) begin
			if (st_q.size() == 0) begin
				abort_run($sformatf("unexpected store at %0t ns", $time));
			end
			st_e = st_q.pop_front();
			lag  = 32'(($time - drive_t[st_e.rec]) / PERIOD);
			check_value("st_valid_o", 32'(st_valid_o), 32'd1);
			check_value("st_valid_o lag", lag, 32'(CHECK_LAG));
			check_value("st_addr_o", st_addr_o, st_e.addr);
			check_value("st_data_o", st_data_o, st_e.data);
			check_value("st_size_o", 32'(st_size_o), 32'(st_e.size));
		end
		if (br_taken_o !== 1'b0) begin
			if (br_q.size() == 0) begin
				abort_run($sformatf("unexpected taken branch at %0t ns", $time));
			end
			br_e = br_q.pop_front();
			lag  = 32'(($time - drive_t[br_e.rec]) / PERIOD);
			check_value("br_taken_o", 32'(br_taken_o), 32'd1);
			check_value("br_taken_o lag", lag, 32'(CHECK_LAG));
			check_value("br_target_o", br_target_o, br_e.target);
		end
	endtask

	// outputs are registered, stable at the falling edge
	always @(negedge clk_i) begin
		if (checking) begin
			check_retire();
		end
	end

	initial begin
		int n_rec;
		int drain;
		int pending;
		clk_i        = 1'b0;
		rst_i        = 1'b1;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		pc_i         = '0;
		checking     = 1'b0;
		load_trace(n_rec);
		$display("trace loaded, %0d records", n_rec);
		repeat (5) @(posedge clk_i);
		// pipeline flushed by now, strobes must stay low
		checking = 1'b1;
		@(negedge clk_i);
		rst_i = 1'b0;
		for (int r = 0; r < n_rec; r++) begin
			@(negedge clk_i);
			drive_record(r);
		end
		@(negedge clk_i);
		inst_valid_i = 1'b0;
		inst_i       = '0;
		pc_i         = '0;
		// wait for the last events to retire
		drain   = 0;
		pending = wb_q.size() + st_q.size() + br_q.size();
		while (pending != 0 && drain < DRAIN_LIMIT) begin
			@(negedge clk_i);
			drain++;
			pending = wb_q.size() + st_q.size() + br_q.size();
		end
		// a few quiet cycles catch stray strobes
		repeat (4) @(negedge clk_i);
		pending = wb_q.size() + st_q.size() + br_q.size();
		if (pending != 0) begin
			abort_run($sformatf("timeout with %0d writes, %0d stores, %0d branches not seen",
				wb_q.size(), st_q.size(), br_q.size()));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: source/rv_exe_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the three stage execute pipeline
// decode, register file and execute plus retire ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rv_exe_top (
	input  wire logic                          clk_i,
	input  wire logic                          rst_i,
	input  wire logic                          inst_valid_i,
	input  wire rv_exe_pkg::inst_u             inst_i,
	input  wire logic [rv_exe_pkg::XLEN-1:0]   pc_i,
	output logic                               wb_valid_o,
	output logic      [rv_exe_pkg::REG_AW-1:0] wb_rd_o,
	output logic      [rv_exe_pkg::XLEN-1:0]   wb_data_o,
	output logic                               st_valid_o,
	output logic      [rv_exe_pkg::XLEN-1:0]   st_addr_o,
	output logic      [rv_exe_pkg::XLEN-1:0]   st_data_o,
	output rv_exe_pkg::store_e                 st_size_o,
	output logic                               br_taken_o,
	output logic      [rv_exe_pkg::XLEN-1:0]   br_target_o
);

	logic [rv_exe_pkg::REG_AW-1:0] rs1_addr;
	logic [rv_exe_pkg::REG_AW-1:0] rs2_addr;
	logic [rv_exe_pkg::XLEN-1:0]   rs1_data;
	logic [rv_exe_pkg::XLEN-1:0]   rs2_data;
	logic                          rf_wr_en;
	rv_exe_pkg::id_ex_t            id_ex;
	rv_exe_pkg::ex_rt_t            ex_byp;
	rv_exe_pkg::ex_rt_t            ex_rt;

	inst_decode inst_decode_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.ex_byp_i     (ex_byp),
		.rt_byp_i     (ex_rt),
		.id_ex_o      (id_ex)
	);

	// retire writes back, never into x0
	assign rf_wr_en = ex_rt.valid && ex_rt.wr_en && (ex_rt.rd != '0);

	reg_file reg_file_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rd_addr1_i (rs1_addr),
		.rd_addr2_i (rs2_addr),
		.rd_data1_o (rs1_data),
		.rd_data2_o (rs2_data),
		.wr_en_i    (rf_wr_en),
		.wr_addr_i  (ex_rt.rd),
		.wr_data_i  (ex_rt.result)
	);

	exe_stage exe_stage_i (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.id_ex_i  (id_ex),
		.ex_byp_o (ex_byp),
		.ex_rt_o  (ex_rt)
	);

	// retire events, x0 writes still reported
	assign wb_valid_o  = ex_rt.valid && ex_rt.wr_en;
	assign wb_rd_o     = ex_rt.rd;
	assign wb_data_o   = ex_rt.result;
	assign st_valid_o  = ex_rt.valid && (ex_rt.st_type != rv_exe_pkg::ST_NONE);
	assign st_addr_o   = ex_rt.st_addr;
	assign st_data_o   = ex_rt.st_data;
	assign st_size_o   = ex_rt.st_type;
	assign br_taken_o  = ex_rt.br_taken;
	assign br_target_o = ex_rt.br_target;

endmodule

`default_nettype wire

// File: source/exe_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage of the pipeline
// operand select, alu, branch decision, store masking
// execute to retire pipeline register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module exe_stage (
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  wire rv_exe_pkg::id_ex_t id_ex_i,
	output rv_exe_pkg::ex_rt_t      ex_byp_o,
	output rv_exe_pkg::ex_rt_t      ex_rt_o
);

	logic [rv_exe_pkg::XLEN-1:0] src1;
	logic [rv_exe_pkg::XLEN-1:0] src2;
	logic [rv_exe_pkg::XLEN-1:0] alu_res;
	logic [rv_exe_pkg::XLEN-1:0] st_mask;
	logic                        alu_zero;
	logic                        alu_lt;
	logic                        alu_ltu;
	logic                        br_cond;
	rv_exe_pkg::ex_rt_t          ex_pkt;
	rv_exe_pkg::ex_rt_t          ex_rt_q;

	// first operand
	always_comb begin
		case (id_ex_i.src1_sel)
			rv_exe_pkg::SRC1_REG1: src1 = id_ex_i.rs1_val;
			rv_exe_pkg::SRC1_PC:   src1 = id_ex_i.pc;
			default:               src1 = '0;
		endcase
	end

	// second operand, four is the jal link step
	always_comb begin
		case (id_ex_i.src2_sel)
			rv_exe_pkg::SRC2_REG2: src2 = id_ex_i.rs2_val;
			rv_exe_pkg::SRC2_IMM:  src2 = id_ex_i.imm;
			rv_exe_pkg::SRC2_FOUR: src2 = 32'd4;
			default:               src2 = '0;
		endcase
	end

	alu alu_i (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (id_ex_i.alu_op),
		.result_o (alu_res),
		.zero_o   (alu_zero),
		.lt_o     (alu_lt),
		.ltu_o    (alu_ltu)
	);

	// branch condition from the compare flags
	always_comb begin
		case (id_ex_i.br_type)
			rv_exe_pkg::BR_BEQ:  br_cond = alu_zero;
			rv_exe_pkg::BR_BNE:  br_cond = !alu_zero;
			rv_exe_pkg::BR_BLT:  br_cond = alu_lt;
			rv_exe_pkg::BR_BGE:  br_cond = !alu_lt;
			rv_exe_pkg::BR_BLTU: br_cond = alu_ltu;
			rv_exe_pkg::BR_BGEU: br_cond = !alu_ltu;
			rv_exe_pkg::BR_JUMP: br_cond = 1'b1;
			default:             br_cond = 1'b0;
		endcase
	end

	// keep only the lanes the store writes
	always_comb begin
		case (id_ex_i.st_type)
			rv_exe_pkg::ST_SB: st_mask = rv_exe_pkg::ST_SB_MASK;
			rv_exe_pkg::ST_SH: st_mask = rv_exe_pkg::ST_SH_MASK;
			rv_exe_pkg::ST_SW: st_mask = rv_exe_pkg::ST_SW_MASK;
			default:           st_mask = '0;
		endcase
	end

	// packet leaving execute, also the young bypass source
	always_comb begin
		ex_pkt.valid     = id_ex_i.valid;
		ex_pkt.wr_en     = id_ex_i.wr_en;
		ex_pkt.rd        = id_ex_i.rd;
		ex_pkt.result    = alu_res;
		ex_pkt.st_type   = id_ex_i.st_type;
		ex_pkt.st_addr   = alu_res;
		ex_pkt.st_data   = id_ex_i.rs2_val & st_mask;
		ex_pkt.br_taken  = id_ex_i.valid && br_cond;
		ex_pkt.br_target = id_ex_i.pc + id_ex_i.imm;
	end

	assign ex_byp_o = ex_pkt;

	// execute to retire register
	always_ff @(posedge clk_i) begin
		ex_rt_q <= ex_pkt;
		if (rst_i) begin
			ex_rt_q.valid    <= 1'b0;
			ex_rt_q.br_taken <= 1'b0;
		end
	end

	assign ex_rt_o = ex_rt_q;

	// retire never reports a store together with a write
	retire_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
		ex_rt_q.valid |-> !(ex_rt_q.wr_en && ex_rt_q.st_type != rv_exe_pkg::ST_NONE));

endmodule

`default_nettype wire

// File: source/inst_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage of the execute pipeline
// format decode, immediate build, operand read with bypass
// decode to execute pipeline register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module inst_decode (
	input  wire logic                                clk_i,
	input  wire logic                                rst_i,
	input  wire logic                                inst_valid_i,
	input  wire rv_exe_pkg::inst_u                   inst_i,
	input  wire logic [rv_exe_pkg::XLEN-1:0]         pc_i,
	output logic      [rv_exe_pkg::REG_AW-1:0]       rs1_addr_o,
	output logic      [rv_exe_pkg::REG_AW-1:0]       rs2_addr_o,
	input  wire logic [rv_exe_pkg::XLEN-1:0]         rs1_data_i,
	input  wire logic [rv_exe_pkg::XLEN-1:0]         rs2_data_i,
	input  wire rv_exe_pkg::ex_rt_t                  ex_byp_i,
	input  wire rv_exe_pkg::ex_rt_t                  rt_byp_i,
	output rv_exe_pkg::id_ex_t                       id_ex_o
);

	// alu op from funct3, alt only counts for sub and sra
	function automatic rv_exe_pkg::alu_op_e alu_from_funct(
		input logic [2:0] f3,
		input logic       alt,
		input logic       is_reg
	);
		rv_exe_pkg::alu_op_e op;
		unique case (f3)
			rv_exe_pkg::F3_ADD_SUB: op = (alt && is_reg) ? rv_exe_pkg::ALU_SUB : rv_exe_pkg::ALU_ADD;
			rv_exe_pkg::F3_SLL:     op = rv_exe_pkg::ALU_SLL;
			rv_exe_pkg::F3_SLT:     op = rv_exe_pkg::ALU_SLT;
			rv_exe_pkg::F3_SLTU:    op = rv_exe_pkg::ALU_SLTU;
			rv_exe_pkg::F3_XOR:     op = rv_exe_pkg::ALU_XOR;
			rv_exe_pkg::F3_SRL_SRA: op = alt ? rv_exe_pkg::ALU_SRA : rv_exe_pkg::ALU_SRL;
			rv_exe_pkg::F3_OR:      op = rv_exe_pkg::ALU_OR;
			default:                op = rv_exe_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	// younger in-flight result first, then retire, then register file
	function automatic logic [rv_exe_pkg::XLEN-1:0] pick_operand(
		input logic [rv_exe_pkg::REG_AW-1:0] idx,
		input logic [rv_exe_pkg::XLEN-1:0]   rf_val,
		input rv_exe_pkg::ex_rt_t            ex,
		input rv_exe_pkg::ex_rt_t            rt
	);
		logic [rv_exe_pkg::XLEN-1:0] val;
		val = rf_val;
		if (idx != '0) begin
			if (ex.valid && ex.wr_en && ex.rd == idx) begin
				val = ex.result;
			end else if (rt.valid && rt.wr_en && rt.rd == idx) begin
				val = rt.result;
			end
		end
		return val;
	endfunction

	logic [rv_exe_pkg::XLEN-1:0] imm_i;
	logic [rv_exe_pkg::XLEN-1:0] imm_s;
	logic [rv_exe_pkg::XLEN-1:0] imm_b;
	logic [rv_exe_pkg::XLEN-1:0] imm_u;
	logic [rv_exe_pkg::XLEN-1:0] imm_j;
	logic                        known;
	logic                        alt;
	rv_exe_pkg::id_ex_t          dec;
	rv_exe_pkg::id_ex_t          id_ex_q;

	// register indices sit in the same place for every format
	assign rs1_addr_o = inst_i.r_fmt.rs1;
	assign rs2_addr_o = inst_i.r_fmt.rs2;
	assign alt = (inst_i.r_fmt.funct7 == rv_exe_pkg::F7_ALT);

	// sign extended immediates per format
	assign imm_i = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
	assign imm_s = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
	assign imm_b = {{19{inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm12, inst_i.b_fmt.imm11,
	                inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};
	assign imm_u = {inst_i.u_fmt.imm31_12, 12'b0};
	assign imm_j = {{11{inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm20, inst_i.j_fmt.imm19_12,
	                inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};

	always_comb begin
		dec          = '0;
		known        = 1'b1;
		dec.pc       = pc_i;
		dec.rd       = inst_i.r_fmt.rd;
		dec.rs1_val  = pick_operand(rs1_addr_o, rs1_data_i, ex_byp_i, rt_byp_i);
		dec.rs2_val  = pick_operand(rs2_addr_o, rs2_data_i, ex_byp_i, rt_byp_i);
		// defaults fit the register-immediate form
		dec.src1_sel = rv_exe_pkg::SRC1_REG1;
		dec.src2_sel = rv_exe_pkg::SRC2_IMM;
		dec.alu_op   = rv_exe_pkg::ALU_ADD;
		dec.br_type  = rv_exe_pkg::BR_NONE;
		dec.st_type  = rv_exe_pkg::ST_NONE;
		case (inst_i.r_fmt.opcode)
			rv_exe_pkg::OPC_LUI: begin
				// upper immediate passes straight through
				dec.imm      = imm_u;
				dec.src1_sel = rv_exe_pkg::SRC1_ZERO;
				dec.alu_op   = rv_exe_pkg::ALU_PASS_B;
				dec.wr_en    = 1'b1;
			end
			rv_exe_pkg::OPC_AUIPC: begin
				dec.imm      = imm_u;
				dec.src1_sel = rv_exe_pkg::SRC1_PC;
				dec.wr_en    = 1'b1;
			end
			rv_exe_pkg::OPC_JAL: begin
				// link value pc + 4, target from imm
				dec.imm      = imm_j;
				dec.src1_sel = rv_exe_pkg::SRC1_PC;
				dec.src2_sel = rv_exe_pkg::SRC2_FOUR;
				dec.br_type  = rv_exe_pkg::BR_JUMP;
				dec.wr_en    = 1'b1;
			end
			rv_exe_pkg::OPC_OP_IMM: begin
				dec.imm    = imm_i;
				dec.alu_op = alu_from_funct(inst_i.i_fmt.funct3, alt, 1'b0);
				dec.wr_en  = 1'b1;
			end
			rv_exe_pkg::OPC_OP: begin
				dec.src2_sel = rv_exe_pkg::SRC2_REG2;
				dec.alu_op   = alu_from_funct(inst_i.r_fmt.funct3, alt, 1'b1);
				dec.wr_en    = 1'b1;
			end
			rv_exe_pkg::OPC_BRANCH: begin
				// alu compares rs1 with rs2 for the flags
				dec.imm      = imm_b;
				dec.src2_sel = rv_exe_pkg::SRC2_REG2;
				dec.alu_op   = rv_exe_pkg::ALU_SUB;
				case (inst_i.b_fmt.funct3)
					rv_exe_pkg::F3_BEQ:  dec.br_type = rv_exe_pkg::BR_BEQ;
					rv_exe_pkg::F3_BNE:  dec.br_type = rv_exe_pkg::BR_BNE;
					rv_exe_pkg::F3_BLT:  dec.br_type = rv_exe_pkg::BR_BLT;
					rv_exe_pkg::F3_BGE:  dec.br_type = rv_exe_pkg::BR_BGE;
					rv_exe_pkg::F3_BLTU: dec.br_type = rv_exe_pkg::BR_BLTU;
					rv_exe_pkg::F3_BGEU: dec.br_type = rv_exe_pkg::BR_BGEU;
					default:             known = 1'b0;
				endcase
			end
			rv_exe_pkg::OPC_STORE: begin
				// address is rs1 + imm, no register write
				dec.imm = imm_s;
				case (inst_i.s_fmt.funct3)
					rv_exe_pkg::F3_SB: dec.st_type = rv_exe_pkg::ST_SB;
					rv_exe_pkg::F3_SH: dec.st_type = rv_exe_pkg::ST_SH;
					rv_exe_pkg::F3_SW: dec.st_type = rv_exe_pkg::ST_SW;
					default:           known = 1'b0;
				endcase
			end
			default: begin
				// anything else becomes a bubble
				known = 1'b0;
			end
		endcase
		dec.valid = inst_valid_i && known;
	end

	// decode to execute register
	always_ff @(posedge clk_i) begin
		id_ex_q <= dec;
		if (rst_i) begin
			id_ex_q.valid <= 1'b0;
		end
	end

	assign id_ex_o = id_ex_q;

	// stores never claim a register write
	store_no_write_a: assert property (@(posedge clk_i) disable iff (rst_i)
		id_ex_q.valid |-> !(id_ex_q.wr_en && id_ex_q.st_type != rv_exe_pkg::ST_NONE));

endmodule

`default_nettype wire

// File: source/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 by 32 integer register file
// two combinational read ports and one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module reg_file (
	input  wire logic                          clk_i,
	input  wire logic                          rst_i,
	input  wire logic [rv_exe_pkg::REG_AW-1:0] rd_addr1_i,
	input  wire logic [rv_exe_pkg::REG_AW-1:0] rd_addr2_i,
	output logic      [rv_exe_pkg::XLEN-1:0]   rd_data1_o,
	output logic      [rv_exe_pkg::XLEN-1:0]   rd_data2_o,
	input  wire logic                          wr_en_i,
	input  wire logic [rv_exe_pkg::REG_AW-1:0] wr_addr_i,
	input  wire logic [rv_exe_pkg::XLEN-1:0]   wr_data_i
);

	logic [rv_exe_pkg::XLEN-1:0] regs [2**rv_exe_pkg::REG_AW];

	// whole file cleared on reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < 2**rv_exe_pkg::REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// x0 reads zero whatever the array holds
	assign rd_data1_o = (rd_addr1_i == '0) ? '0 : regs[rd_addr1_i];
	assign rd_data2_o = (rd_addr2_i == '0) ? '0 : regs[rd_addr2_i];

	// top filters out x0 writes before they get here
	no_x0_write_a: assert property (@(posedge clk_i) disable iff (rst_i)
		wr_en_i |-> wr_addr_i != '0);

endmodule

`default_nettype wire

// File: source/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer alu for the execute stage
// arithmetic, logic and shifts plus compare flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module alu (
	input  wire logic [rv_exe_pkg::XLEN-1:0] src1_i,
	input  wire logic [rv_exe_pkg::XLEN-1:0] src2_i,
	input  wire rv_exe_pkg::alu_op_e         alu_op_i,
	output logic      [rv_exe_pkg::XLEN-1:0] result_o,
	output logic                             zero_o,
	output logic                             lt_o,
	output logic                             ltu_o
);

	logic [4:0] shamt;

	// only the low five bits shift
	assign shamt = src2_i[4:0];

	// compare flags straight from the operands
	assign zero_o = (src1_i == src2_i);
	assign lt_o   = ($signed(src1_i) < $signed(src2_i));
	assign ltu_o  = (src1_i < src2_i);

	always_comb begin
		case (alu_op_i)
			rv_exe_pkg::ALU_ADD:    result_o = src1_i + src2_i;
			rv_exe_pkg::ALU_SUB:    result_o = src1_i - src2_i;
			rv_exe_pkg::ALU_SLL:    result_o = src1_i << shamt;
			rv_exe_pkg::ALU_SLT:    result_o = {{(rv_exe_pkg::XLEN-1){1'b0}}, lt_o};
			rv_exe_pkg::ALU_SLTU:   result_o = {{(rv_exe_pkg::XLEN-1){1'b0}}, ltu_o};
			rv_exe_pkg::ALU_XOR:    result_o = src1_i ^ src2_i;
			rv_exe_pkg::ALU_SRL:    result_o = src1_i >> shamt;
			// arithmetic shift keeps the sign
			rv_exe_pkg::ALU_SRA:    result_o = $unsigned($signed(src1_i) >>> shamt);
			rv_exe_pkg::ALU_OR:     result_o = src1_i | src2_i;
			rv_exe_pkg::ALU_AND:    result_o = src1_i & src2_i;
			rv_exe_pkg::ALU_PASS_B: result_o = src2_i;
			default:                result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/rv_exe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions of the integer execute pipeline
// widths, opcode and funct constants, control enums
// instruction format union and the two stage packets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_exe_pkg;

	// datapath and register index widths
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// major opcodes of the kept subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// funct3 of alu ops, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 that turns add into sub and srl into sra
	localparam logic [6:0] F7_ALT = 7'b0100000;

	// branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// store funct3
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {SRC1_ZERO, SRC1_REG1, SRC1_PC} src1_sel_e;
	typedef enum logic [1:0] {SRC2_REG2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JUMP
	} branch_e;

	// store width and the byte lanes it keeps
	typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} store_e;
	localparam logic [XLEN-1:0] ST_SB_MASK = 32'h0000_00ff;
	localparam logic [XLEN-1:0] ST_SH_MASK = 32'h0000_ffff;
	localparam logic [XLEN-1:0] ST_SW_MASK = 32'hffff_ffff;

	// instruction formats, msb first
	typedef struct packed {
		logic [6:0]        funct7;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]       imm;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]        imm_hi;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [4:0]        imm_lo;
		logic [6:0]        opcode;
	} s_fmt_t;

	typedef struct packed {
		logic              imm12;
		logic [5:0]        imm10_5;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [3:0]        imm4_1;
		logic              imm11;
		logic [6:0]        opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]       imm31_12;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} u_fmt_t;

	typedef struct packed {
		logic              imm20;
		logic [9:0]        imm10_1;
		logic              imm11;
		logic [7:0]        imm19_12;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} j_fmt_t;

	// one word, six views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	// decode to execute
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   rs1_val;
		logic [XLEN-1:0]   rs2_val;
		logic [XLEN-1:0]   imm;
		alu_op_e           alu_op;
		src1_sel_e         src1_sel;
		src2_sel_e         src2_sel;
		branch_e           br_type;
		store_e            st_type;
		logic              wr_en;
		logic [REG_AW-1:0] rd;
	} id_ex_t;

	// execute to retire
	typedef struct packed {
		logic              valid;
		logic              wr_en;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   result;
		store_e            st_type;
		logic [XLEN-1:0]   st_addr;
		logic [XLEN-1:0]   st_data;
		logic              br_taken;
		logic [XLEN-1:0]   br_target;
	} ex_rt_t;

endpackage

`default_nettype wire
